/* tb/dma_offload_stim.txt */
// Per frame: payload_words rem flag_word src_len task_word
// then the payload words, then the four expected completion words; 0 ends the list
// "abc", run without stalls
1 1 20000000 00000003 00000001
61626300
200005C2 00000003 35244001 352441C2
// "123456789", junk in the reserved header bits
3 7 A5A51234 00000009 FFFFF3C7
31323334 35363738 39000000
A0000526 00000009 CBF43BC7 CBF43926
// a to z, declared length too long
7 3 E0000000 0000001E 00000200
61626364 65666768 696A6B6C 6D6E6F70 71727374 75767778 797A0000
F00004BD 0000001A 4C275200 4C2750BD
// 32 zero bytes
8 0 40000000 00000020 000003FF
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
400005AD 00000020 190A57FF 190A55AD
// "a", declared length too long
1 7 00000000 00000002 00000155
61000000
10000643 00000001 E8B7BD55 E8B7BE43
0

/* all.f */
+incdir+src
src/dma_offload_pkg.sv
src/llink_hdr_parser.sv
src/payload_crc.sv
src/cpl_framer.sv
src/dma_offload_top.sv
tb/tb_clkgen.sv
tb/dma_offload_chk.sv
tb/dma_offload_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dma_offload_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/dma_offload_tb.sv */
`default_nettype none

`include "dma_offload_config.svh"

module dma_offload_tb
   import dma_offload_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int STIM_DEPTH = 256;

   logic        clk;
   logic        rst_n;
   ll_beat_t    in_beat;
   logic        in_valid;
   logic        in_ready;
   logic [31:0] cpl_data;
   logic        cpl_last;
   logic        cpl_valid;
   logic        cpl_ready;

   logic [31:0] stim_mem [STIM_DEPTH];
   logic [31:0] lfsr;
   int          cycles = 0;
   int          cycle_limit = 0;
   int          eof_edge = 0;

   tb_clkgen clkgen0 (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   dma_offload_top dut0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .cpl_data_o  (cpl_data),
      .cpl_last_o  (cpl_last),
      .cpl_valid_o (cpl_valid),
      .cpl_ready_i (cpl_ready)
   );

   bind dma_offload_top dma_offload_chk chk0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_beat_i   (in_beat_i),
      .in_valid_i  (in_valid_i),
      .in_ready_i  (in_ready_o),
      .cpl_data_i  (cpl_data_o),
      .cpl_last_i  (cpl_last_o),
      .cpl_valid_i (cpl_valid_o),
      .cpl_ready_i (cpl_ready_i)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   // Edge count, read on the falling edge
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit)
         fail_run("Timeout: the DUT stopped making progress within the cycle limit");
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Two bits per draw, so about one stall in four
   task automatic draw_stall(output logic stall);
      logic b0;
      lfsr = lfsr_next(lfsr);
      b0 = lfsr[0];
      lfsr = lfsr_next(lfsr);
      stall = b0 & lfsr[0];
   endtask

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                            $time, what, got, exp));
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                            $time, what, got, exp));
   endtask

   // Completion word 1 seen through the header flag view
   task automatic check_desc_status(input hdr_word_u got, input hdr_word_u hdr,
                                    input logic mism);
      if (got.flag_v.op_flags !== hdr.flag_v.op_flags ||
          got.flag_v.rsvd[28] !== mism || got.flag_v.rsvd[10] !== 1'b1)
         fail_run($sformatf("CHECK FAILED at %0t: status %h, flags %b mismatch %b expected",
                            $time, got, hdr.flag_v.op_flags, mism));
   endtask

   function automatic int rem_bytes(input logic [3:0] rem);
      case (rem)
         4'b0000: return 4;
         4'b0001: return 3;
         4'b0011: return 2;
         default: return 1;
      endcase
   endfunction

   task automatic send_beat(input ll_beat_t beat, input logic gaps);
      logic sent;
      logic gap;
      sent = 1'b0;
      while (!sent) begin
         @(negedge clk);
         gap = 1'b0;
         if (gaps)
            draw_stall(gap);
         in_beat = beat;
         in_valid = !gap;
         sent = !gap && in_ready;
      end
      eof_edge = cycles + 1;
   endtask

   // Record: count, rem, flag word, length, task word, payload, 4 expected words
   task automatic run_frame(input int base, input int f);
      int          n;
      int          w;
      int          exp_bytes;
      logic [3:0]  rem;
      logic        stalls;
      logic        stall;
      logic        seen;
      ll_beat_t    beat;
      logic [31:0] got [`DOFF_CPL_WORDS];
      n = int'(stim_mem[base]);
      rem = stim_mem[base + 1][3:0];
      stalls = (f != 0);
      for (int k = 0; k < `DOFF_HDR_WORDS + n; k++) begin
         if (k >= `DOFF_FLAG_WORD && k <= `DOFF_TASK_WORD)
            beat.data = stim_mem[base + 2 + k - `DOFF_FLAG_WORD];
         else if (k < `DOFF_HDR_WORDS)
            beat.data = {16'h4844, 8'(f), 8'(k)};
         else
            beat.data = stim_mem[base + 5 + k - `DOFF_HDR_WORDS];
         beat.sof = (k == 0);
         beat.eof = (k == `DOFF_HDR_WORDS + n - 1);
         beat.rem = beat.eof ? rem : 4'b0000;
         send_beat(beat, stalls);
      end
      w = 0;
      seen = 1'b0;
      while (w < `DOFF_CPL_WORDS) begin
         @(negedge clk);
         in_valid = 1'b0;
         stall = 1'b0;
         if (stalls)
            draw_stall(stall);
         cpl_ready = !stall;
         // First edge that can take word 1
         if (cpl_valid && !seen) begin
            seen = 1'b1;
            if (!stalls)
               check_word("completion latency", 32'(cycles + 1 - eof_edge), 32'd2);
         end
         if (cpl_valid && cpl_ready) begin
            check_flag("cpl_last", cpl_last, w == `DOFF_CPL_WORDS - 1);
            got[w] = cpl_data;
            w++;
         end
      end
      @(negedge clk);
      cpl_ready = 1'b0;
      check_flag("cpl_valid after word 4", cpl_valid, 1'b0);
      check_flag("in_ready after completion", in_ready, 1'b1);
      exp_bytes = (n - 1) * 4 + rem_bytes(rem);
      check_desc_status(got[0], stim_mem[base + 2], exp_bytes != stim_mem[base + 3]);
      check_word("byte count", got[1], 32'(exp_bytes));
      for (int i = 0; i < `DOFF_CPL_WORDS; i++)
         check_word($sformatf("frame %0d word %0d", f, i + 1), got[i],
                    stim_mem[base + 5 + n + i]);
   endtask

   initial begin
      int idx;
      int frames;
      int total;
      in_beat = '0;
      in_valid = 1'b0;
      cpl_ready = 1'b0;
      lfsr = 32'hbaa7_ebd8;
      $readmemh("tb/dma_offload_stim.txt", stim_mem);
      idx = 0;
      total = 0;
      while (idx < STIM_DEPTH && stim_mem[idx] != 32'd0) begin
         total += `DOFF_HDR_WORDS + int'(stim_mem[idx]) + `DOFF_CPL_WORDS;
         idx += 5 + int'(stim_mem[idx]) + `DOFF_CPL_WORDS;
      end
      if (total == 0)
         fail_run("No frames could be read from tb/dma_offload_stim.txt");
      cycle_limit = total * 20;
      @(posedge rst_n);
      idx = 0;
      frames = 0;
      while (idx < STIM_DEPTH && stim_mem[idx] != 32'd0) begin
         run_frame(idx, frames);
         idx += 5 + int'(stim_mem[idx]) + `DOFF_CPL_WORDS;
         frames++;
      end
      $display("%0d frames checked", frames);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/dma_offload_chk.sv */
`default_nettype none

module dma_offload_chk
   import dma_offload_pkg::*;
(
   input logic        clk,
   input logic        rst_n,
   input ll_beat_t    in_beat_i,
   input logic        in_valid_i,
   input logic        in_ready_i,
   input logic [31:0] cpl_data_i,
   input logic        cpl_last_i,
   input logic        cpl_valid_i,
   input logic        cpl_ready_i
);

   timeunit 1ns;
   timeprecision 100ps;

   // Completion word held while stalled
   cpl_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_valid_i && !cpl_ready_i |=>
         cpl_valid_i && $stable(cpl_data_i) && $stable(cpl_last_i))
      else $error("completion word changed while stalled");

   // No request accepted while a completion is pending
   pending_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
      cpl_valid_i |-> !in_ready_i)
      else $error("in_ready high while a completion is pending");

   eof_drops_ready: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid_i && in_ready_i && in_beat_i.eof |=> !in_ready_i)
      else $error("in_ready still high after the eof transfer");

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
   output logic clk_o,
   output logic rst_n_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // 8 ns period
   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   // Four rising edges in reset, released away from the edge
   initial begin
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

/* src/dma_offload_top.sv */
`default_nettype none

module dma_offload_top
   import dma_offload_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  ll_beat_t    in_beat_i,
   input  logic        in_valid_i,
   output logic        in_ready_o,
   output logic [31:0] cpl_data_o,
   output logic        cpl_last_o,
   output logic        cpl_valid_o,
   input  logic        cpl_ready_i
);

   ll_beat_t pay_beat;
   logic     pay_valid;
   desc_t    desc;
   logic     desc_valid;
   crc_t     crc;
   logic     crc_valid;
   logic     cpl_done;

   llink_hdr_parser u_parser (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_beat_i    (in_beat_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .pay_beat_o   (pay_beat),
      .pay_valid_o  (pay_valid),
      .desc_o       (desc),
      .desc_valid_o (desc_valid),
      .cpl_done_i   (cpl_done)
   );

   payload_crc u_crc (
      .clk         (clk),
      .rst_n       (rst_n),
      .pay_beat_i  (pay_beat),
      .pay_valid_i (pay_valid),
      .crc_o       (crc),
      .crc_valid_o (crc_valid)
   );

   cpl_framer u_framer (
      .clk          (clk),
      .rst_n        (rst_n),
      .desc_i       (desc),
      .desc_valid_i (desc_valid),
      .crc_i        (crc),
      .crc_valid_i  (crc_valid),
      .cpl_data_o   (cpl_data_o),
      .cpl_last_o   (cpl_last_o),
      .cpl_valid_o  (cpl_valid_o),
      .cpl_ready_i  (cpl_ready_i),
      .cpl_done_o   (cpl_done)
   );

endmodule

`default_nettype wire

/* src/cpl_framer.sv */
`default_nettype none

`include "dma_offload_config.svh"

module cpl_framer
   import dma_offload_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  desc_t       desc_i,
   input  logic        desc_valid_i,
   input  crc_t        crc_i,
   input  logic        crc_valid_i,
   output logic [31:0] cpl_data_o,
   output logic        cpl_last_o,
   output logic        cpl_valid_o,
   input  logic        cpl_ready_i,
   output logic        cpl_done_o
);

   desc_t      desc_q;
   crc_t       crc_q;
   logic       have_desc;
   logic       have_crc;
   logic       start;
   logic       xfer;
   logic       mismatch;
   logic [1:0] word_idx;

   assign start      = (have_desc || desc_valid_i) && (have_crc || crc_valid_i);
   assign xfer       = cpl_valid_o && cpl_ready_i;
   assign mismatch   = (desc_q.byte_cnt != desc_q.src_len);
   assign cpl_last_o = cpl_valid_o && (word_idx == 2'(`DOFF_CPL_WORDS - 1));
   assign cpl_done_o = xfer && cpl_last_o;

   always_ff @(posedge clk) begin
      if (desc_valid_i)
         desc_q <= desc_i;
      if (crc_valid_i)
         crc_q <= crc_i;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         have_desc   <= 1'b0;
         have_crc    <= 1'b0;
         cpl_valid_o <= 1'b0;
         word_idx    <= 2'd0;
      end else begin
         have_desc <= !start && (have_desc || desc_valid_i);
         have_crc  <= !start && (have_crc || crc_valid_i);
         if (start) begin
            cpl_valid_o <= 1'b1;
            word_idx    <= 2'd0;
         end else if (xfer) begin
            if (cpl_last_o)
               cpl_valid_o <= 1'b0;
            else
               word_idx <= word_idx + 2'd1;
         end
      end
   end

   // Status, byte count, CRC high with task, full CRC
   always_comb begin
      case (word_idx)
         2'd0:    cpl_data_o = {desc_q.op_flags, mismatch, 17'h0, 1'b1, crc_q[9:0]};
         2'd1:    cpl_data_o = desc_q.byte_cnt;
         2'd2:    cpl_data_o = {crc_q[31:`DOFF_TASK_W], desc_q.task_index};
         default: cpl_data_o = crc_q;
      endcase
   end

endmodule

`default_nettype wire

/* src/payload_crc.sv */
`default_nettype none

`include "dma_offload_config.svh"

module payload_crc
   import dma_offload_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  ll_beat_t pay_beat_i,
   input  logic     pay_valid_i,
   output crc_t     crc_o,
   output logic     crc_valid_o
);

   logic in_frame;
   crc_t crc_q;
   crc_t crc_next;

   // One byte through the reflected polynomial, LSB first
   function automatic crc_t crc_byte(input crc_t c, input logic [7:0] b);
      crc_t r;
      r = c ^ {24'h0, b};
      for (int k = 0; k < 8; k++) begin
         r = r[0] ? ((r >> 1) ^ `DOFF_CRC_POLY) : (r >> 1);
      end
      return r;
   endfunction

   // Byte 0 is data[31:24], masked by rem[3]
   always_comb begin
      crc_next = in_frame ? crc_q : `DOFF_CRC_INIT;
      for (int i = 0; i < 4; i++) begin
         if (!pay_beat_i.rem[3-i])
            crc_next = crc_byte(crc_next, pay_beat_i.data[31-8*i -: 8]);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_frame    <= 1'b0;
         crc_valid_o <= 1'b0;
      end else begin
         crc_valid_o <= pay_valid_i && pay_beat_i.eof;
         if (pay_valid_i)
            in_frame <= !pay_beat_i.eof;
      end
   end

   always_ff @(posedge clk) begin
      if (pay_valid_i) begin
         crc_q <= crc_next;
         if (pay_beat_i.eof)
            crc_o <= ~crc_next;
      end
   end

endmodule

`default_nettype wire

/* src/llink_hdr_parser.sv */
`default_nettype none

`include "dma_offload_config.svh"

module llink_hdr_parser
   import dma_offload_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  ll_beat_t in_beat_i,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   output ll_beat_t pay_beat_o,
   output logic     pay_valid_o,
   output desc_t    desc_o,
   output logic     desc_valid_o,
   input  logic     cpl_done_i
);

   logic       accept;
   logic       in_payload;
   logic       busy;
   logic [3:0] hdr_cnt;
   logic [2:0] beat_bytes;
   hdr_word_u  hdr_word;
   desc_t      desc_q;

   assign in_ready_o  = !busy;
   assign accept      = in_valid_i && in_ready_o;
   assign in_payload  = (hdr_cnt == `DOFF_HDR_WORDS);
   assign hdr_word    = in_beat_i.data;
   assign pay_beat_o  = in_beat_i;
   assign pay_valid_o = accept && in_payload;
   assign desc_o      = desc_q;

   // Each zero bit in rem is one valid byte
   always_comb begin
      beat_bytes = 3'd0;
      for (int i = 0; i < 4; i++) begin
         if (!in_beat_i.rem[i])
            beat_bytes = beat_bytes + 3'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hdr_cnt      <= 4'd0;
         busy         <= 1'b0;
         desc_valid_o <= 1'b0;
      end else begin
         desc_valid_o <= pay_valid_o && in_beat_i.eof;
         if (cpl_done_i)
            busy <= 1'b0;
         if (accept) begin
            // sof realigns on header word 0
            if (in_beat_i.sof) begin
               hdr_cnt <= 4'd1;
            end else if (!in_payload) begin
               hdr_cnt <= hdr_cnt + 4'd1;
            end else if (in_beat_i.eof) begin
               hdr_cnt <= 4'd0;
               busy    <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         if (in_beat_i.sof)
            desc_q.byte_cnt <= 32'd0;
         if (hdr_cnt == `DOFF_FLAG_WORD)
            desc_q.op_flags <= hdr_word.flag_v.op_flags;
         if (hdr_cnt == `DOFF_LEN_WORD)
            desc_q.src_len <= in_beat_i.data;
         if (hdr_cnt == `DOFF_TASK_WORD)
            desc_q.task_index <= hdr_word.task_v.task_index;
         if (in_payload)
            desc_q.byte_cnt <= desc_q.byte_cnt + 32'(beat_bytes);
      end
   end

endmodule

`default_nettype wire

/* src/dma_offload_pkg.sv */
`default_nettype none

`include "dma_offload_config.svh"

package dma_offload_pkg;

   // rem marks invalid trailing low bytes, only meaningful on eof
   typedef struct packed {
      logic [31:0] data;
      logic [3:0]  rem;
      logic        sof;
      logic        eof;
   } ll_beat_t;

   typedef struct packed {
      logic [2:0]  op_flags;
      logic [28:0] rsvd;
   } hdr_flag_t;

   typedef struct packed {
      logic [31-`DOFF_TASK_W:0] rsvd;
      logic [`DOFF_TASK_W-1:0]  task_index;
   } hdr_task_t;

   typedef union packed {
      hdr_flag_t flag_v;
      hdr_task_t task_v;
   } hdr_word_u;

   typedef struct packed {
      logic [2:0]              op_flags;
      logic [31:0]             src_len;
      logic [`DOFF_TASK_W-1:0] task_index;
      logic [31:0]             byte_cnt;
   } desc_t;

   typedef logic [31:0] crc_t;

endpackage

`default_nettype wire

/* src/dma_offload_config.svh */
`ifndef DMA_OFFLOAD_CONFIG_SVH
`define DMA_OFFLOAD_CONFIG_SVH

// Request frame layout
`define DOFF_HDR_WORDS 8
`define DOFF_FLAG_WORD 4
`define DOFF_LEN_WORD  5
`define DOFF_TASK_WORD 6

// Completion frame layout
`define DOFF_CPL_WORDS 4

// Reflected CRC-32, final value is inverted
`define DOFF_CRC_POLY 32'hEDB88320
`define DOFF_CRC_INIT 32'hFFFFFFFF

// Task index carried in header word 6
`define DOFF_TASK_W 10

`endif
